//--- include/instr_dispatch_params.svh
`ifndef INSTR_DISPATCH_PARAMS_SVH
`define INSTR_DISPATCH_PARAMS_SVH

// Instruction payload bits
`define ID_PAYLOAD_W 32

// Payload plus the last-word flag on top
`define ID_WORD_W (`ID_PAYLOAD_W + 1)

`define ID_DEPTH 16     // Words per channel buffer
`define ID_CHANNELS 2

`endif

//--- logic/instr_dispatch_pkg.sv
`include "instr_dispatch_params.svh"

package instr_dispatch_pkg;

    // Stored instruction word, top bit marks end of program
    typedef logic [`ID_WORD_W-1:0] instr_word_t;

    typedef logic [`ID_PAYLOAD_W-1:0] payload_t;

    typedef logic chan_t;

    // Wide enough to hold ID_DEPTH itself
    typedef logic [$clog2(`ID_DEPTH):0] count_t;

    typedef struct packed {
        chan_t       chan;
        instr_word_t word;
    } host_wr_t;

    typedef struct packed {
        chan_t    chan;
        logic     last;
        payload_t payload;
    } cmd_t;

    typedef enum logic {
        ARB_IDLE,
        ARB_BUSY
    } arb_state_t;

endpackage

//--- logic/instruction_buffer.sv
`timescale 1ns/1ps
`include "instr_dispatch_params.svh"

module instruction_buffer (
    input  logic                            rd_clk,
    input  logic                            reset,
    input  logic                            wr_valid,
    input  instr_dispatch_pkg::instr_word_t wr_data,
    output logic                            wr_ready,
    output logic                            rd_valid,
    input  logic                            rd_ready,
    output instr_dispatch_pkg::payload_t    rd_data,
    output logic                            rd_last
);
    import instr_dispatch_pkg::*;

    localparam int ADDR_W = $clog2(`ID_DEPTH);

    instr_word_t mem [`ID_DEPTH];

    // Pointers carry one wrap bit above the address
    count_t wr_ptr;
    count_t rd_ptr;
    count_t occupancy;      // Words held, including those in flight

    instr_word_t pre_word;  // RAM read stage
    logic        pre_valid;
    instr_word_t out_word;

    logic wr_fire;
    logic rd_fire;
    logic out_free;
    logic rd_issue;

    assign wr_ready = occupancy < count_t'(`ID_DEPTH);
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    // Output register empty, or being emptied this cycle
    assign out_free = !rd_valid || rd_ready;

    // One word in the read stage at a time
    assign rd_issue = (rd_ptr != wr_ptr) && !pre_valid && out_free;

    always_ff @(posedge rd_clk) begin
        if (wr_fire) begin
            mem[wr_ptr[ADDR_W-1:0]] <= wr_data;
        end
        if (rd_issue) begin
            pre_word <= mem[rd_ptr[ADDR_W-1:0]];
        end
    end

    always_ff @(posedge rd_clk) begin
        if (pre_valid && out_free) begin
            out_word <= pre_word;
        end
    end

    always_ff @(posedge rd_clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            occupancy <= '0;
            pre_valid <= 1'b0;
            rd_valid  <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_issue) begin
                rd_ptr <= rd_ptr + 1'b1;
            end

            case ({wr_fire, rd_fire})
                2'b10: occupancy <= occupancy + 1'b1;
                2'b01: occupancy <= occupancy - 1'b1;
                default: begin
                end
            endcase

            pre_valid <= rd_issue || (pre_valid && !out_free);

            if (out_free) begin
                rd_valid <= pre_valid;  // Load next or go empty
            end
        end
    end

    assign rd_data = out_word[`ID_PAYLOAD_W-1:0];
    assign rd_last = out_word[`ID_WORD_W-1];

endmodule

//--- logic/load_router.sv
`timescale 1ns/1ps
`include "instr_dispatch_params.svh"

module load_router (
    input  logic                            rd_clk,
    input  logic                            reset,
    input  instr_dispatch_pkg::host_wr_t    host_wr,
    input  logic                            host_valid,
    output logic                            host_ready,
    output logic [`ID_CHANNELS-1:0]         wr_valid,
    output instr_dispatch_pkg::instr_word_t wr_data,
    input  logic [`ID_CHANNELS-1:0]         wr_ready,
    input  logic                            prog_done,
    input  instr_dispatch_pkg::chan_t       done_chan,
    output logic [`ID_CHANNELS-1:0]         pending
);
    import instr_dispatch_pkg::*;

    // Complete programs waiting per channel
    count_t prog_cnt [`ID_CHANNELS];

    logic host_fire;
    logic last_in;

    assign host_ready = wr_ready[host_wr.chan];
    assign host_fire  = host_valid && host_ready;
    assign last_in    = host_wr.word[`ID_WORD_W-1];
    assign wr_data    = host_wr.word;   // Shared, valid picks the target

    for (genvar c = 0; c < `ID_CHANNELS; c++) begin : g_chan
        logic sel;
        logic inc;
        logic dec;

        assign sel         = host_wr.chan == chan_t'(c);
        assign wr_valid[c] = host_valid && sel;
        assign inc         = host_fire && sel && last_in;
        assign dec         = prog_done && (done_chan == chan_t'(c));

        always_ff @(posedge rd_clk) begin
            if (reset) begin
                prog_cnt[c] <= '0;
            end else if (inc && !dec) begin
                prog_cnt[c] <= prog_cnt[c] + 1'b1;
            end else if (dec && !inc) begin
                prog_cnt[c] <= prog_cnt[c] - 1'b1;
            end
        end

        assign pending[c] = prog_cnt[c] != '0;
    end

endmodule

//--- logic/dispatch_arbiter.sv
`timescale 1ns/1ps
`include "instr_dispatch_params.svh"

module dispatch_arbiter (
    input  logic                                             rd_clk,
    input  logic                                             reset,
    input  logic [`ID_CHANNELS-1:0]                          pending,
    input  logic [`ID_CHANNELS-1:0]                          rd_valid,
    input  instr_dispatch_pkg::payload_t [`ID_CHANNELS-1:0]  rd_data,
    input  logic [`ID_CHANNELS-1:0]                          rd_last,
    output logic [`ID_CHANNELS-1:0]                          rd_ready,
    output instr_dispatch_pkg::cmd_t                         cmd,
    output logic                                             cmd_valid,
    input  logic                                             cmd_ready,
    output logic                                             prog_done,
    output instr_dispatch_pkg::chan_t                        done_chan
);
    import instr_dispatch_pkg::*;

    arb_state_t state;
    chan_t      grant;
    chan_t      last_grant;     // Channel of the last finished program
    chan_t      other;
    chan_t      pick;
    logic       busy;
    logic       want;

    // Round-robin between the two channels
    assign other = ~last_grant;
    assign pick  = pending[other] ? other : last_grant;
    assign want  = |pending;
    assign busy  = state == ARB_BUSY;

    // Granted program passes straight through
    always_comb begin
        cmd.chan    = grant;
        cmd.last    = rd_last[grant];
        cmd.payload = rd_data[grant];
    end

    assign cmd_valid = busy && rd_valid[grant];

    always_comb begin
        rd_ready = '0;
        if (busy) begin
            rd_ready[grant] = cmd_ready;
        end
    end

    // Same cycle as the last transfer, so pending is current when idle
    assign prog_done = cmd_valid && cmd_ready && rd_last[grant];
    assign done_chan = grant;

    always_ff @(posedge rd_clk) begin
        if (reset) begin
            state      <= ARB_IDLE;
            grant      <= '0;
            last_grant <= 1'b1;     // Channel 0 goes first
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (want) begin
                        state <= ARB_BUSY;
                        grant <= pick;
                    end
                end
                ARB_BUSY: begin
                    if (prog_done) begin
                        state      <= ARB_IDLE;
                        last_grant <= grant;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

endmodule

//--- logic/instr_dispatch_top.sv
`timescale 1ns/1ps
`include "instr_dispatch_params.svh"

module instr_dispatch_top (
    input  logic                         rd_clk,
    input  logic                         reset,
    input  instr_dispatch_pkg::host_wr_t host_wr,
    input  logic                         host_valid,
    output logic                         host_ready,
    output instr_dispatch_pkg::cmd_t     cmd,
    output logic                         cmd_valid,
    input  logic                         cmd_ready
);
    import instr_dispatch_pkg::*;

    logic [`ID_CHANNELS-1:0]     wr_valid;
    logic [`ID_CHANNELS-1:0]     wr_ready;
    instr_word_t                 wr_data;

    logic [`ID_CHANNELS-1:0]     rd_valid;
    logic [`ID_CHANNELS-1:0]     rd_ready;
    logic [`ID_CHANNELS-1:0]     rd_last;
    payload_t [`ID_CHANNELS-1:0] rd_data;

    logic [`ID_CHANNELS-1:0]     pending;
    logic                        prog_done;
    chan_t                       done_chan;

    load_router u_router (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .host_wr    (host_wr),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .wr_valid   (wr_valid),
        .wr_data    (wr_data),
        .wr_ready   (wr_ready),
        .prog_done  (prog_done),
        .done_chan  (done_chan),
        .pending    (pending)
    );

    for (genvar c = 0; c < `ID_CHANNELS; c++) begin : g_buf
        instruction_buffer u_buf (
            .rd_clk   (rd_clk),
            .reset    (reset),
            .wr_valid (wr_valid[c]),
            .wr_data  (wr_data),
            .wr_ready (wr_ready[c]),
            .rd_valid (rd_valid[c]),
            .rd_ready (rd_ready[c]),
            .rd_data  (rd_data[c]),
            .rd_last  (rd_last[c])
        );
    end

    dispatch_arbiter u_arb (
        .rd_clk    (rd_clk),
        .reset     (reset),
        .pending   (pending),
        .rd_valid  (rd_valid),
        .rd_data   (rd_data),
        .rd_last   (rd_last),
        .rd_ready  (rd_ready),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .prog_done (prog_done),
        .done_chan (done_chan)
    );

endmodule

//--- testbench/instr_dispatch_checker.sv
`timescale 1ns/1ps

module instr_dispatch_checker (
    input logic                         rd_clk,
    input logic                         reset,
    input instr_dispatch_pkg::host_wr_t host_wr,
    input logic                         host_valid,
    input logic                         host_ready,
    input instr_dispatch_pkg::cmd_t     cmd,
    input logic                         cmd_valid,
    input logic                         cmd_ready
);

    int fail_cnt = 0;   // Assertion failures so far

    // Stalled command beat stays put
    cmd_hold: assert property (@(posedge rd_clk) disable iff (reset)
        cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
    else begin
        $error("cmd changed or dropped while stalled");
        fail_cnt++;
    end

    host_hold: assert property (@(posedge rd_clk) disable iff (reset)
        host_valid && !host_ready |=> host_valid && $stable(host_wr))
    else begin
        $error("host write changed or dropped while stalled");
        fail_cnt++;
    end

    cmd_after_reset: assert property (@(posedge rd_clk) reset |=> !cmd_valid)
    else begin
        $error("cmd_valid high right after reset");
        fail_cnt++;
    end

endmodule

bind instr_dispatch_top instr_dispatch_checker chk_i (
    .rd_clk     (rd_clk),
    .reset      (reset),
    .host_wr    (host_wr),
    .host_valid (host_valid),
    .host_ready (host_ready),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .cmd_ready  (cmd_ready)
);

//--- testbench/instr_dispatch_tb.sv
`timescale 1ns/1ps
`include "instr_dispatch_params.svh"

module instr_dispatch_tb;
    import instr_dispatch_pkg::*;

    localparam int TIMEOUT    = 5000;   // Cycles allowed per wait
    localparam int SOAK_BEATS = 300;

    logic     rd_clk = 1'b0;
    logic     reset;
    host_wr_t host_wr;
    logic     host_valid;
    logic     host_ready;
    cmd_t     cmd;
    logic     cmd_valid;
    logic     cmd_ready;

    int ready_mode = 0;     // 0 stall, 1 open, 2 random

    // Reference model, updated by the monitor only
    instr_word_t model_q0 [$];
    instr_word_t model_q1 [$];
    chan_t       prog_chans [$];    // Channel of each finished program
    int          full_progs [2] = '{0, 0};
    logic        in_prog = 1'b0;
    chan_t       cur_chan = 1'b0;
    int          loaded_progs = 0;
    int          done_progs = 0;

    int cmd_errors = 0;
    int bus_errors = 0;
    int value_errors = 0;
    int timeout_errors = 0;

    instr_dispatch_top dut_i (
        .rd_clk     (rd_clk),
        .reset      (reset),
        .host_wr    (host_wr),
        .host_valid (host_valid),
        .host_ready (host_ready),
        .cmd        (cmd),
        .cmd_valid  (cmd_valid),
        .cmd_ready  (cmd_ready)
    );

    always #10 rd_clk = ~rd_clk;

    always begin : ready_driver
        case (ready_mode)
            0: cmd_ready = 1'b0;
            1: cmd_ready = 1'b1;
            default: cmd_ready = ($urandom % 10) >= 3;  // Ready about 70 percent
        endcase
        @(negedge rd_clk);
    end

    task automatic check_cmd(input string name, input cmd_t got, input cmd_t exp);
        if (got !== exp) begin
            cmd_errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input count_t got, input count_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_chan(input string name, input chan_t got, input chan_t exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            value_errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    function automatic int model_size(chan_t ch);
        return ch ? model_q1.size() : model_q0.size();
    endfunction

    // Sampled at the rising edge, before any register updates
    always @(posedge rd_clk) begin : monitor
        cmd_t        exp;
        chan_t       ch;
        instr_word_t word;
        if (!reset && host_valid && host_ready) begin
            if (host_wr.chan) model_q1.push_back(host_wr.word);
            else model_q0.push_back(host_wr.word);
            if (host_wr.word[`ID_WORD_W-1]) begin
                loaded_progs++;
                full_progs[host_wr.chan]++;
            end
        end
        if (!reset && cmd_valid && cmd_ready) begin
            ch = in_prog ? cur_chan : cmd.chan;     // Program must stay on one channel
            if (!in_prog && full_progs[ch] == 0) begin
                bus_errors++;
                $display("ERROR at %0t: program started on channel %0d before it was complete",
                         $time, ch);
            end
            if (model_size(ch) == 0) begin
                bus_errors++;
                $display("ERROR at %0t: extra command beat, nothing queued for channel %0d",
                         $time, ch);
                word = {cmd.last, cmd.payload};
            end else begin
                if (ch) word = model_q1.pop_front();
                else word = model_q0.pop_front();
                exp.chan    = ch;
                exp.last    = word[`ID_WORD_W-1];
                exp.payload = word[`ID_PAYLOAD_W-1:0];
                check_cmd("cmd", cmd, exp);
            end
            in_prog  = !word[`ID_WORD_W-1];
            cur_chan = ch;
            if (cmd.last) begin
                done_progs++;   // Programs ended on the bus
            end
            if (word[`ID_WORD_W-1]) begin
                if (full_progs[ch] > 0) full_progs[ch]--;
                prog_chans.push_back(ch);
            end
        end
    end

    // Holds valid and data until the beat transfers
    task automatic send_word(input chan_t ch, input instr_word_t w);
        int waited;
        host_wr.chan = ch;
        host_wr.word = w;
        host_valid   = 1'b1;
        waited       = 0;
        do begin
            @(posedge rd_clk);
            waited++;
        end while (!host_ready && waited < TIMEOUT);
        if (!host_ready) begin
            timeout_errors++;
            $display("ERROR at %0t: host write to channel %0d was never accepted", $time, ch);
        end
        @(negedge rd_clk);
        host_valid = 1'b0;
    endtask

    task automatic send_program(input chan_t ch, input int len);
        for (int i = 0; i < len; i++) begin
            send_word(ch, {i == len - 1, payload_t'($urandom)});
        end
    endtask

    task automatic wait_drain();
        int waited = 0;
        while ((model_q0.size() != 0 || model_q1.size() != 0) && waited < TIMEOUT) begin
            @(negedge rd_clk);
            waited++;
        end
        if (model_q0.size() != 0 || model_q1.size() != 0) begin
            timeout_errors++;
            $display("ERROR at %0t: command bus did not drain in time", $time);
        end
    endtask

    // Needs the post-reset arbiter state, so it runs first
    task automatic round_robin_test();
        ready_mode = 0;
        for (int i = 0; i < 6; i++) begin
            send_program(chan_t'(i % 2), 1 + int'($urandom % 5));
        end
        ready_mode = 1;
        wait_drain();
        check_count("round-robin programs", count_t'(prog_chans.size()), count_t'(6));
        for (int i = 0; i < prog_chans.size() && i < 6; i++) begin
            check_chan("program channel", prog_chans[i], chan_t'(i % 2));
        end
    endtask

    task automatic back_pressure_test();
        ready_mode = 0;
        for (int i = 0; i < `ID_DEPTH - 1; i++) begin
            send_word(1'b1, {1'b0, payload_t'($urandom)});
        end
        repeat (8) begin    // Open program, bus stays quiet
            @(posedge rd_clk);
            check_flag("cmd_valid", cmd_valid, 1'b0);
        end
        @(negedge rd_clk);
        send_word(1'b1, {1'b1, payload_t'($urandom)});
        host_wr.chan = 1'b1;
        @(posedge rd_clk);
        check_flag("host_ready ch1", host_ready, 1'b0);
        @(negedge rd_clk);
        host_wr.chan = 1'b0;
        @(posedge rd_clk);
        check_flag("host_ready ch0", host_ready, 1'b1);
        @(negedge rd_clk);
        ready_mode = 1;
        send_word(1'b1, {1'b1, payload_t'($urandom)});  // Fits once a word leaves
        wait_drain();
    endtask

    task automatic soak_test();
        int beats = 0;
        int len;
        ready_mode = 2;
        while (beats < SOAK_BEATS) begin
            len = 1 + int'($urandom % 6);
            if (len > SOAK_BEATS - beats) len = SOAK_BEATS - beats;
            send_program(chan_t'($urandom % 2), len);
            beats += len;
        end
        wait_drain();
    endtask

    initial begin : stimulus
        int asserts;
        void'($urandom(32'h96e6_2d5d));
        reset      = 1'b1;
        host_wr    = '0;
        host_valid = 1'b0;
        repeat (2) @(posedge rd_clk);
        @(negedge rd_clk);
        reset = 1'b0;

        round_robin_test();
        back_pressure_test();
        soak_test();

        check_count("model queue ch0", count_t'(model_q0.size()), '0);
        check_count("model queue ch1", count_t'(model_q1.size()), '0);
        check_count("programs outstanding", count_t'(loaded_progs - done_progs), '0);
        asserts = dut_i.chk_i.fail_cnt;
        $display("Errors: cmd %0d, bus %0d, value %0d, timeout %0d, assertion %0d",
                 cmd_errors, bus_errors, value_errors, timeout_errors, asserts);
        if (cmd_errors + bus_errors + value_errors + timeout_errors + asserts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+include
logic/instr_dispatch_pkg.sv
logic/instruction_buffer.sv
logic/load_router.sv
logic/dispatch_arbiter.sv
logic/instr_dispatch_top.sv
testbench/instr_dispatch_checker.sv
testbench/instr_dispatch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the instruction dispatcher testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=instr_dispatch_tb

verilator --binary --timing --assert -f tb.f --top-module "$TOP" -Mdir obj_dir -o sim_bin
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench gives its verdict
./obj_dir/sim_bin +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
    echo "Result: fail"
    exit 1
fi
if ! grep -q "TB PASSED" "$LOG"; then
    echo "Result: no verdict found in $LOG"
    exit 1
fi

echo "Result: pass"
exit 0
